// File: vlog.f
gpio_pkg.sv
gpio_reg_top.sv
gpio_input_filter.sv
gpio_intr.sv
gpio.sv
gpio_sva.sv
tb_gpio.sv

// File: run.sh
#!/usr/bin/env bash
# Build and run the gpio testbench with Verilator; exit status follows the test result
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal --top-module tb_gpio -f vlog.f \
  > build.log 2>&1 \
  && ./obj_dir/Vtb_gpio > sim.log 2>&1 \
  || { echo "build or simulation failed, see build.log and sim.log"; exit 1; }

grep -q "errors found" sim.log && { echo "FAIL"; exit 1; } || { echo "PASS"; exit 0; }

// File: tb_gpio.sv
// Testbench for the gpio block; runs a table of bus, pin and output checks against expected values
`timescale 1ns/1ps
`default_nettype none

module tb_gpio;

  import gpio_pkg::*;

  typedef enum logic [2:0] {
    act_write, act_read, act_pins, act_wait, act_out, act_oe, act_irq
  } act_e;

  typedef struct packed {
    act_e        act;
    logic [7:0]  addr;
    logic [31:0] data;
    logic [31:0] exp;
    logic        exp_err;
    logic [2:0]  test_id;
  } entry_t;

  logic                  clk_i;
  logic                  rst_ni;
  tl_h2d_t               tl_i;
  tl_d2h_t               tl_o;
  logic [gpio_width-1:0] cio_gpio_i;
  logic [gpio_width-1:0] cio_gpio_o;
  logic [gpio_width-1:0] cio_gpio_en_o;
  logic [gpio_width-1:0] intr_gpio_o;

  entry_t      entries[$];
  logic [2:0]  cur_test;
  int          checks;
  int          errors;
  int          test_errors;
  int          cycles;
  int          cycle_limit;
  logic [31:0] pins_a;
  string       test_names [6] = '{"reset values", "out and oe writes", "unfiltered input",
                                  "filtered input", "edge interrupts", "level interrupts"};

  gpio DUT (
    .clk_i         (clk_i),
    .rst_ni        (rst_ni),
    .tl_i          (tl_i),
    .tl_o          (tl_o),
    .cio_gpio_i    (cio_gpio_i),
    .cio_gpio_o    (cio_gpio_o),
    .cio_gpio_en_o (cio_gpio_en_o),
    .intr_gpio_o   (intr_gpio_o)
  );

  initial begin
    clk_i = 1'b0;
    forever #2 clk_i = ~clk_i;
  end

  always @(posedge clk_i) begin
    cycles <= cycles + 1;
    if (cycle_limit != 0 && cycles > cycle_limit) begin
      $display("Timeout: the run went past %0d cycles without finishing", cycle_limit);
      $display("Done: errors found");
      $finish;
    end
  end

  function automatic void push_entry(act_e act, logic [7:0] addr, logic [31:0] data,
                                     logic [31:0] exp, logic exp_err);
    entries.push_back('{act, addr, data, exp, exp_err, cur_test});
  endfunction

  // Bits under the mask take the new data, the rest keep their value
  function automatic logic [15:0] masked_merge(logic [15:0] cur, logic [15:0] mask,
                                               logic [15:0] data);
    return (data & mask) | (cur & ~mask);
  endfunction

  function automatic void build_out_tests(logic [7:0] direct_a, logic [7:0] lower_a,
                                          logic [7:0] upper_a, act_e chk);
    logic [31:0] model;
    logic [31:0] word;
    model = $urandom();
    push_entry(act_write, direct_a, model, '0, 1'b0);
    push_entry(chk, '0, '0, model, 1'b0);
    for (int i = 0; i < 6; i++) begin
      word = $urandom();
      if (i % 2 == 0) begin
        model[15:0] = masked_merge(model[15:0], word[31:16], word[15:0]);
        push_entry(act_write, lower_a, word, '0, 1'b0);
        push_entry(act_read, lower_a, '0, {16'h0, model[15:0]}, 1'b0);
      end else begin
        model[31:16] = masked_merge(model[31:16], word[31:16], word[15:0]);
        push_entry(act_write, upper_a, word, '0, 1'b0);
        push_entry(act_read, upper_a, '0, {16'h0, model[31:16]}, 1'b0);
      end
      push_entry(chk, '0, '0, model, 1'b0);
    end
    push_entry(act_read, direct_a, '0, model, 1'b0);
  endfunction

  task automatic bus_access(input logic wr, input logic [7:0] addr, input logic [31:0] wdata,
                            output logic [31:0] rdata, output logic err);
    @(posedge clk_i);
    tl_i.a_valid   <= 1'b1;
    tl_i.a_opcode  <= wr ? put_full : get;
    tl_i.a_address <= addr;
    tl_i.a_data    <= wdata;
    @(negedge clk_i);
    while (!tl_o.a_ready) @(negedge clk_i);
    // Request is taken on this edge
    @(posedge clk_i);
    tl_i.a_valid <= 1'b0;
    @(negedge clk_i);
    while (!tl_o.d_valid) @(negedge clk_i);
    rdata = tl_o.d_data;
    err   = tl_o.d_error;
  endtask

  task automatic run_entry(input entry_t e);
    logic [31:0] rdata;
    logic [31:0] got;
    logic        err;
    err = 1'b0;
    got = e.exp;
    case (e.act)
      act_write, act_read: begin
        bus_access(e.act == act_write, e.addr, e.data, rdata, err);
        if (e.act == act_read) got = rdata;
      end
      act_pins: begin
        @(posedge clk_i);
        cio_gpio_i <= e.data;
      end
      act_wait: repeat (e.data) @(posedge clk_i);
      default: begin
        @(negedge clk_i);
        if (e.act == act_out) got = cio_gpio_o;
        if (e.act == act_oe) got = cio_gpio_en_o;
        if (e.act == act_irq) got = intr_gpio_o;
      end
    endcase
    if (e.act != act_pins && e.act != act_wait) begin
      checks++;
      if (got !== e.exp || err !== e.exp_err) begin
        errors++;
        test_errors++;
        $display("ERR @%0t: %s addr 0x%02h got %08h err %0b, expected %08h err %0b",
                 $time, e.act.name(), e.addr, got, err, e.exp, e.exp_err);
      end
    end
  endtask

  initial begin
    logic [7:0] readable [14] = '{intr_state, intr_enable, data_in, direct_out,
                                  masked_out_lower, masked_out_upper, direct_oe,
                                  masked_oe_lower, masked_oe_upper, intr_ctrl_en_rising,
                                  intr_ctrl_en_falling, intr_ctrl_en_lvlhigh,
                                  intr_ctrl_en_lvllow, ctrl_en_input_filter};
    rst_ni      = 1'b0;
    tl_i        = '0;
    tl_i.a_opcode = get;
    tl_i.d_ready  = 1'b1;
    cio_gpio_i  = '0;
    cycles      = 0;
    cycle_limit = 0;
    checks      = 0;
    errors      = 0;
    test_errors = 0;
    void'($urandom(32'h93baa7a9));

    cur_test = 3'd0;
    foreach (readable[i]) push_entry(act_read, readable[i], '0, '0, 1'b0);
    push_entry(act_out, '0, '0, '0, 1'b0);
    push_entry(act_oe, '0, '0, '0, 1'b0);
    push_entry(act_irq, '0, '0, '0, 1'b0);
    push_entry(act_read, 8'h3C, '0, '0, 1'b1);
    push_entry(act_read, intr_test, '0, '0, 1'b1);
    push_entry(act_write, data_in, 32'hFFFF_FFFF, '0, 1'b1);

    cur_test = 3'd1;
    build_out_tests(direct_out, masked_out_lower, masked_out_upper, act_out);
    build_out_tests(direct_oe, masked_oe_lower, masked_oe_upper, act_oe);

    cur_test = 3'd2;
    pins_a = $urandom();
    push_entry(act_pins, '0, pins_a, '0, 1'b0);
    push_entry(act_wait, '0, 32'd3, '0, 1'b0);
    push_entry(act_read, data_in, '0, pins_a, 1'b0);

    // Short pulse on the low byte, then a long change on the upper half
    cur_test = 3'd3;
    push_entry(act_write, ctrl_en_input_filter, 32'hFFFF_FFFF, '0, 1'b0);
    push_entry(act_pins, '0, pins_a ^ 32'h0000_00FF, '0, 1'b0);
    push_entry(act_wait, '0, 32'd2, '0, 1'b0);
    push_entry(act_read, data_in, '0, pins_a, 1'b0);
    push_entry(act_pins, '0, pins_a, '0, 1'b0);
    push_entry(act_wait, '0, 32'd20, '0, 1'b0);
    push_entry(act_read, data_in, '0, pins_a, 1'b0);
    push_entry(act_pins, '0, pins_a ^ 32'hFFFF_0000, '0, 1'b0);
    push_entry(act_wait, '0, 32'd40, '0, 1'b0);
    push_entry(act_read, data_in, '0, pins_a ^ 32'hFFFF_0000, 1'b0);
    push_entry(act_write, ctrl_en_input_filter, '0, '0, 1'b0);
    push_entry(act_pins, '0, '0, '0, 1'b0);
    push_entry(act_wait, '0, 32'd3, '0, 1'b0);
    push_entry(act_read, data_in, '0, '0, 1'b0);

    cur_test = 3'd4;
    push_entry(act_write, intr_enable, 32'h0000_00FF, '0, 1'b0);
    push_entry(act_write, intr_ctrl_en_rising, 32'h0000_0F0F, '0, 1'b0);
    push_entry(act_pins, '0, 32'h0000_0F0F, '0, 1'b0);
    push_entry(act_wait, '0, 32'd4, '0, 1'b0);
    push_entry(act_read, intr_state, '0, 32'h0000_0F0F, 1'b0);
    push_entry(act_irq, '0, '0, 32'h0000_000F, 1'b0);
    push_entry(act_write, intr_state, 32'h0000_0F00, '0, 1'b0);
    push_entry(act_read, intr_state, '0, 32'h0000_000F, 1'b0);
    push_entry(act_write, intr_state, 32'h0000_000F, '0, 1'b0);
    push_entry(act_read, intr_state, '0, '0, 1'b0);
    push_entry(act_irq, '0, '0, '0, 1'b0);
    push_entry(act_write, intr_test, 32'h0000_0030, '0, 1'b0);
    push_entry(act_read, intr_state, '0, 32'h0000_0030, 1'b0);
    push_entry(act_irq, '0, '0, 32'h0000_0030, 1'b0);
    push_entry(act_write, intr_state, 32'h0000_0030, '0, 1'b0);
    push_entry(act_read, intr_state, '0, '0, 1'b0);
    push_entry(act_write, intr_ctrl_en_rising, '0, '0, 1'b0);

    cur_test = 3'd5;
    push_entry(act_write, intr_enable, 32'h0001_0000, '0, 1'b0);
    push_entry(act_write, intr_ctrl_en_lvlhigh, 32'h0001_0000, '0, 1'b0);
    push_entry(act_pins, '0, 32'h0001_0000, '0, 1'b0);
    push_entry(act_wait, '0, 32'd4, '0, 1'b0);
    push_entry(act_read, intr_state, '0, 32'h0001_0000, 1'b0);
    push_entry(act_irq, '0, '0, 32'h0001_0000, 1'b0);
    push_entry(act_write, intr_state, 32'h0001_0000, '0, 1'b0);
    push_entry(act_read, intr_state, '0, 32'h0001_0000, 1'b0);
    push_entry(act_pins, '0, '0, '0, 1'b0);
    push_entry(act_wait, '0, 32'd4, '0, 1'b0);
    push_entry(act_write, intr_state, 32'h0001_0000, '0, 1'b0);
    push_entry(act_wait, '0, 32'd4, '0, 1'b0);
    push_entry(act_read, intr_state, '0, '0, 1'b0);
    push_entry(act_irq, '0, '0, '0, 1'b0);

    cycle_limit = entries.size() * 64 + 100;

    repeat (10) @(posedge clk_i);
    rst_ni <= 1'b1;

    foreach (entries[i]) begin
      run_entry(entries[i]);
      if (i == entries.size() - 1 || entries[i+1].test_id != entries[i].test_id) begin
        $display("test %0d %s: %s, %0d errors", entries[i].test_id,
                 test_names[entries[i].test_id], test_errors == 0 ? "ok" : "failed",
                 test_errors);
        test_errors = 0;
      end
    end

    $display("Summary: %0d checks, %0d errors", checks, errors);
    if (errors == 0) begin
      $display("Done: no errors");
    end else begin
      $display("Done: errors found");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: gpio_sva.sv
// Bus protocol and reset-value assertions for gpio; attached to every gpio instance by bind
`timescale 1ns/1ps
`default_nettype none

module gpio_sva (
  input logic                            clk_i,
  input logic                            rst_ni,
  input gpio_pkg::tl_h2d_t               tl_i,
  input gpio_pkg::tl_d2h_t               tl_o,
  input logic [gpio_pkg::gpio_width-1:0] cio_gpio_o,
  input logic [gpio_pkg::gpio_width-1:0] cio_gpio_en_o,
  input logic [gpio_pkg::gpio_width-1:0] intr_gpio_o
);

  // Response stays put until the host takes it
  rsp_held: assert property (@(posedge clk_i) disable iff (!rst_ni)
    tl_o.d_valid && !tl_i.d_ready |=> tl_o.d_valid && $stable(tl_o.d_data) &&
                                      $stable(tl_o.d_error))
    else $error("response changed or dropped before d_ready");

  // Taken request gets its response next cycle and blocks a_ready
  accept_then_response: assert property (@(posedge clk_i) disable iff (!rst_ni)
    tl_i.a_valid && tl_o.a_ready |=> tl_o.d_valid && !tl_o.a_ready)
    else $error("no response, or a_ready still high, in the cycle after a request was taken");

  reset_values: assert property (@(posedge clk_i)
    $rose(rst_ni) |-> cio_gpio_o == '0 && cio_gpio_en_o == '0 && intr_gpio_o == '0 &&
                      tl_o.a_ready && !tl_o.d_valid)
    else $error("outputs not at reset values after reset release");

endmodule

bind gpio gpio_sva u_sva (
  .clk_i         (clk_i),
  .rst_ni        (rst_ni),
  .tl_i          (tl_i),
  .tl_o          (tl_o),
  .cio_gpio_o    (cio_gpio_o),
  .cio_gpio_en_o (cio_gpio_en_o),
  .intr_gpio_o   (intr_gpio_o)
);

`default_nettype wire

// File: gpio.sv
// GPIO top level; owns the out/oe registers and ties together registers, filter and interrupts
`timescale 1ns/1ps
`default_nettype none

module gpio (
  input  logic                            clk_i,
  input  logic                            rst_ni,
  input  gpio_pkg::tl_h2d_t               tl_i,
  output gpio_pkg::tl_d2h_t               tl_o,
  input  logic [gpio_pkg::gpio_width-1:0] cio_gpio_i,
  output logic [gpio_pkg::gpio_width-1:0] cio_gpio_o,
  output logic [gpio_pkg::gpio_width-1:0] cio_gpio_en_o,
  output logic [gpio_pkg::gpio_width-1:0] intr_gpio_o
);

  import gpio_pkg::*;

  gpio_reg2hw_t          reg2hw;
  gpio_hw2reg_t          hw2reg;
  logic [gpio_width-1:0] out_q;
  logic [gpio_width-1:0] oe_q;
  logic [gpio_width-1:0] data_filt;

  // Direct write wins, then upper half, then lower half
  function automatic logic [gpio_width-1:0] apply_write(
    input logic [gpio_width-1:0] cur,
    input gpio_reg_wq_t          direct,
    input gpio_reg_masked_t      upper,
    input gpio_reg_masked_t      lower
  );
    logic [gpio_width-1:0] nxt;
    nxt = cur;
    if (direct.qe) begin
      nxt = direct.q;
    end else if (upper.qe) begin
      nxt[gpio_width-1:gpio_width/2] = (upper.mask & upper.data) |
                                       (~upper.mask & cur[gpio_width-1:gpio_width/2]);
    end else if (lower.qe) begin
      nxt[gpio_width/2-1:0] = (lower.mask & lower.data) |
                              (~lower.mask & cur[gpio_width/2-1:0]);
    end
    return nxt;
  endfunction

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      out_q <= '0;
      oe_q  <= '0;
    end else begin
      out_q <= apply_write(out_q, reg2hw.direct_out,
                           reg2hw.masked_out_upper, reg2hw.masked_out_lower);
      oe_q  <= apply_write(oe_q, reg2hw.direct_oe,
                           reg2hw.masked_oe_upper, reg2hw.masked_oe_lower);
    end
  end

  assign cio_gpio_o    = out_q;
  assign cio_gpio_en_o = oe_q;

  assign hw2reg.data_in = data_filt;
  assign hw2reg.out     = out_q;
  assign hw2reg.oe      = oe_q;

  gpio_reg_top u_reg (
    .clk_i    (clk_i),
    .rst_ni   (rst_ni),
    .tl_i     (tl_i),
    .tl_o     (tl_o),
    .reg2hw_o (reg2hw),
    .hw2reg_i (hw2reg)
  );

  gpio_input_filter u_filter (
    .clk_i    (clk_i),
    .rst_ni   (rst_ni),
    .enable_i (reg2hw.ctrl_en_input_filter),
    .data_i   (cio_gpio_i),
    .data_o   (data_filt)
  );

  gpio_intr u_intr (
    .clk_i           (clk_i),
    .rst_ni          (rst_ni),
    .data_i          (data_filt),
    .reg2hw_i        (reg2hw),
    .intr_state_o    (hw2reg.intr_state),
    .intr_state_de_o (hw2reg.intr_state_de),
    .intr_o          (intr_gpio_o)
  );

endmodule

`default_nettype wire

// File: gpio_intr.sv
// GPIO interrupt logic; turns edge and level events into intr_state updates and the irq vector
`timescale 1ns/1ps
`default_nettype none

module gpio_intr (
  input  logic                            clk_i,
  input  logic                            rst_ni,
  input  logic [gpio_pkg::gpio_width-1:0] data_i,
  input  gpio_pkg::gpio_reg2hw_t          reg2hw_i,
  output logic [gpio_pkg::gpio_width-1:0] intr_state_o,
  output logic                            intr_state_de_o,
  output logic [gpio_pkg::gpio_width-1:0] intr_o
);

  import gpio_pkg::*;

  logic [gpio_width-1:0] data_prev_q;
  logic [gpio_width-1:0] ev_rise;
  logic [gpio_width-1:0] ev_fall;
  logic [gpio_width-1:0] ev_high;
  logic [gpio_width-1:0] ev_low;
  logic [gpio_width-1:0] ev_test;
  logic [gpio_width-1:0] ev_set;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      data_prev_q <= '0;
    end else begin
      data_prev_q <= data_i;
    end
  end

  assign ev_rise = ~data_prev_q &  data_i & reg2hw_i.intr_ctrl_en_rising;
  assign ev_fall =  data_prev_q & ~data_i & reg2hw_i.intr_ctrl_en_falling;
  assign ev_high =  data_i & reg2hw_i.intr_ctrl_en_lvlhigh;
  assign ev_low  = ~data_i & reg2hw_i.intr_ctrl_en_lvllow;
  assign ev_test = reg2hw_i.intr_test.q & {gpio_width{reg2hw_i.intr_test.qe}};

  assign ev_set = ev_rise | ev_fall | ev_high | ev_low | ev_test;

  // Set beats a same-cycle software clear
  assign intr_state_o    = (reg2hw_i.intr_state & ~reg2hw_i.intr_state_clr) | ev_set;
  assign intr_state_de_o = |ev_set;

  assign intr_o = reg2hw_i.intr_state & reg2hw_i.intr_enable;

endmodule

`default_nettype wire

// File: gpio_input_filter.sv
// Per-pin glitch filter bank; a pin change passes only after it holds for filter_cycles samples
`timescale 1ns/1ps
`default_nettype none

module gpio_input_filter (
  input  logic                            clk_i,
  input  logic                            rst_ni,
  input  logic [gpio_pkg::gpio_width-1:0] enable_i,
  input  logic [gpio_pkg::gpio_width-1:0] data_i,
  output logic [gpio_pkg::gpio_width-1:0] data_o
);

  import gpio_pkg::*;

  for (genvar i = 0; i < gpio_width; i++) begin : gen_pin
    logic                        stable_q;
    logic [filter_cnt_width-1:0] cnt_q;

    always_ff @(posedge clk_i or negedge rst_ni) begin
      if (!rst_ni) begin
        stable_q <= 1'b0;
        cnt_q    <= '0;
      end else if (!enable_i[i]) begin
        // Bypass: just one register stage
        stable_q <= data_i[i];
        cnt_q    <= '0;
      end else if (data_i[i] == stable_q) begin
        cnt_q <= '0;
      end else if (cnt_q == filter_cnt_width'(filter_cycles - 1)) begin
        stable_q <= data_i[i];
        cnt_q    <= '0;
      end else begin
        cnt_q <= cnt_q + 1'b1;
      end
    end

    assign data_o[i] = stable_q;
  end

endmodule

`default_nettype wire

// File: gpio_reg_top.sv
// GPIO register block; single-outstanding bus slave that holds config registers and drives reg2hw
`timescale 1ns/1ps
`default_nettype none

module gpio_reg_top (
  input  logic                   clk_i,
  input  logic                   rst_ni,
  input  gpio_pkg::tl_h2d_t      tl_i,
  output gpio_pkg::tl_d2h_t      tl_o,
  output gpio_pkg::gpio_reg2hw_t reg2hw_o,
  input  gpio_pkg::gpio_hw2reg_t hw2reg_i
);

  import gpio_pkg::*;

  gpio_reg_e             reg_addr;
  logic                  accept;
  logic                  is_read;
  logic                  wr_en;
  logic                  req_err;
  logic [31:0]           rdata;
  logic                  rsp_pending_q;
  logic [31:0]           rsp_data_q;
  logic                  rsp_error_q;
  logic [gpio_width-1:0] intr_state_q;
  logic [gpio_width-1:0] intr_enable_q;
  logic [gpio_width-1:0] en_rising_q;
  logic [gpio_width-1:0] en_falling_q;
  logic [gpio_width-1:0] en_lvlhigh_q;
  logic [gpio_width-1:0] en_lvllow_q;
  logic [gpio_width-1:0] filter_en_q;
  logic [gpio_width-1:0] intr_clr;

  assign reg_addr = gpio_reg_e'(tl_i.a_address);
  assign accept   = tl_i.a_valid & ~rsp_pending_q;
  assign is_read  = (tl_i.a_opcode == get);
  assign wr_en    = accept & (tl_i.a_opcode == put_full) & ~req_err;

  // Read mux and access checks
  always_comb begin
    rdata   = '0;
    req_err = 1'b0;
    case (reg_addr)
      intr_state:           rdata = intr_state_q;
      intr_enable:          rdata = intr_enable_q;
      intr_test:            req_err = is_read;
      data_in: begin
        rdata   = hw2reg_i.data_in;
        req_err = ~is_read;
      end
      direct_out:           rdata = hw2reg_i.out;
      masked_out_lower:     rdata = {16'h0, hw2reg_i.out[gpio_width/2-1:0]};
      masked_out_upper:     rdata = {16'h0, hw2reg_i.out[gpio_width-1:gpio_width/2]};
      direct_oe:            rdata = hw2reg_i.oe;
      masked_oe_lower:      rdata = {16'h0, hw2reg_i.oe[gpio_width/2-1:0]};
      masked_oe_upper:      rdata = {16'h0, hw2reg_i.oe[gpio_width-1:gpio_width/2]};
      intr_ctrl_en_rising:  rdata = en_rising_q;
      intr_ctrl_en_falling: rdata = en_falling_q;
      intr_ctrl_en_lvlhigh: rdata = en_lvlhigh_q;
      intr_ctrl_en_lvllow:  rdata = en_lvllow_q;
      ctrl_en_input_filter: rdata = filter_en_q;
      default:              req_err = 1'b1;
    endcase
  end

  assign intr_clr = (wr_en && reg_addr == intr_state) ? tl_i.a_data : '0;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      intr_state_q  <= '0;
      intr_enable_q <= '0;
      en_rising_q   <= '0;
      en_falling_q  <= '0;
      en_lvlhigh_q  <= '0;
      en_lvllow_q   <= '0;
      filter_en_q   <= '0;
    end else begin
      // Hardware load already folds in the clear
      if (hw2reg_i.intr_state_de) begin
        intr_state_q <= hw2reg_i.intr_state;
      end else begin
        intr_state_q <= intr_state_q & ~intr_clr;
      end
      if (wr_en && reg_addr == intr_enable)          intr_enable_q <= tl_i.a_data;
      if (wr_en && reg_addr == intr_ctrl_en_rising)  en_rising_q   <= tl_i.a_data;
      if (wr_en && reg_addr == intr_ctrl_en_falling) en_falling_q  <= tl_i.a_data;
      if (wr_en && reg_addr == intr_ctrl_en_lvlhigh) en_lvlhigh_q  <= tl_i.a_data;
      if (wr_en && reg_addr == intr_ctrl_en_lvllow)  en_lvllow_q   <= tl_i.a_data;
      if (wr_en && reg_addr == ctrl_en_input_filter) filter_en_q   <= tl_i.a_data;
    end
  end

  // Response channel
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      rsp_pending_q <= 1'b0;
    end else if (accept) begin
      rsp_pending_q <= 1'b1;
    end else if (tl_i.d_ready) begin
      rsp_pending_q <= 1'b0;
    end
  end

  always_ff @(posedge clk_i) begin
    if (accept) begin
      rsp_data_q  <= (is_read && !req_err) ? rdata : '0;
      rsp_error_q <= req_err;
    end
  end

  assign tl_o.a_ready = ~rsp_pending_q;
  assign tl_o.d_valid = rsp_pending_q;
  assign tl_o.d_data  = rsp_data_q;
  assign tl_o.d_error = rsp_error_q;

  assign reg2hw_o.direct_out.q  = tl_i.a_data;
  assign reg2hw_o.direct_out.qe = wr_en & (reg_addr == direct_out);
  assign reg2hw_o.direct_oe.q   = tl_i.a_data;
  assign reg2hw_o.direct_oe.qe  = wr_en & (reg_addr == direct_oe);
  assign reg2hw_o.intr_test.q   = tl_i.a_data;
  assign reg2hw_o.intr_test.qe  = wr_en & (reg_addr == intr_test);

  assign reg2hw_o.masked_out_lower = '{tl_i.a_data[31:16], tl_i.a_data[15:0],
                                       wr_en & (reg_addr == masked_out_lower)};
  assign reg2hw_o.masked_out_upper = '{tl_i.a_data[31:16], tl_i.a_data[15:0],
                                       wr_en & (reg_addr == masked_out_upper)};
  assign reg2hw_o.masked_oe_lower  = '{tl_i.a_data[31:16], tl_i.a_data[15:0],
                                       wr_en & (reg_addr == masked_oe_lower)};
  assign reg2hw_o.masked_oe_upper  = '{tl_i.a_data[31:16], tl_i.a_data[15:0],
                                       wr_en & (reg_addr == masked_oe_upper)};

  assign reg2hw_o.intr_state           = intr_state_q;
  assign reg2hw_o.intr_enable          = intr_enable_q;
  assign reg2hw_o.intr_ctrl_en_rising  = en_rising_q;
  assign reg2hw_o.intr_ctrl_en_falling = en_falling_q;
  assign reg2hw_o.intr_ctrl_en_lvlhigh = en_lvlhigh_q;
  assign reg2hw_o.intr_ctrl_en_lvllow  = en_lvllow_q;
  assign reg2hw_o.ctrl_en_input_filter = filter_en_q;
  assign reg2hw_o.intr_state_clr       = intr_clr;

endmodule

`default_nettype wire

// File: gpio_pkg.sv
// Shared GPIO constants, bus and register-interface types; imported by the RTL and testbench
`default_nettype none

package gpio_pkg;

  localparam int gpio_width       = 32;
  localparam int filter_cycles    = 16;
  localparam int filter_cnt_width = $clog2(filter_cycles);

  // TL-UL opcode encodings, single-beat subset
  typedef enum logic [2:0] {
    put_full = 3'h0,
    get      = 3'h4
  } tl_opcode_e;

  typedef enum logic [7:0] {
    intr_state           = 8'h00,
    intr_enable          = 8'h04,
    intr_test            = 8'h08,
    data_in              = 8'h0C,
    direct_out           = 8'h10,
    masked_out_lower     = 8'h14,
    masked_out_upper     = 8'h18,
    direct_oe            = 8'h1C,
    masked_oe_lower      = 8'h20,
    masked_oe_upper      = 8'h24,
    intr_ctrl_en_rising  = 8'h28,
    intr_ctrl_en_falling = 8'h2C,
    intr_ctrl_en_lvlhigh = 8'h30,
    intr_ctrl_en_lvllow  = 8'h34,
    ctrl_en_input_filter = 8'h38
  } gpio_reg_e;

  typedef struct packed {
    logic        a_valid;
    tl_opcode_e  a_opcode;
    logic [7:0]  a_address;
    logic [31:0] a_data;
    logic        d_ready;
  } tl_h2d_t;

  typedef struct packed {
    logic        a_ready;
    logic        d_valid;
    logic [31:0] d_data;
    logic        d_error;
  } tl_d2h_t;

  typedef struct packed {
    logic [gpio_width-1:0] q;
    logic                  qe;
  } gpio_reg_wq_t;

  // Upper half of the bus word is the mask, lower half the data
  typedef struct packed {
    logic [gpio_width/2-1:0] mask;
    logic [gpio_width/2-1:0] data;
    logic                    qe;
  } gpio_reg_masked_t;

  typedef struct packed {
    gpio_reg_wq_t          direct_out;
    gpio_reg_wq_t          direct_oe;
    gpio_reg_wq_t          intr_test;
    gpio_reg_masked_t      masked_out_lower;
    gpio_reg_masked_t      masked_out_upper;
    gpio_reg_masked_t      masked_oe_lower;
    gpio_reg_masked_t      masked_oe_upper;
    logic [gpio_width-1:0] intr_state;
    logic [gpio_width-1:0] intr_enable;
    logic [gpio_width-1:0] intr_ctrl_en_rising;
    logic [gpio_width-1:0] intr_ctrl_en_falling;
    logic [gpio_width-1:0] intr_ctrl_en_lvlhigh;
    logic [gpio_width-1:0] intr_ctrl_en_lvllow;
    logic [gpio_width-1:0] ctrl_en_input_filter;
    logic [gpio_width-1:0] intr_state_clr;
  } gpio_reg2hw_t;

  typedef struct packed {
    logic [gpio_width-1:0] data_in;
    logic [gpio_width-1:0] out;
    logic [gpio_width-1:0] oe;
    logic [gpio_width-1:0] intr_state;
    logic                  intr_state_de;
  } gpio_hw2reg_t;

endpackage

`default_nettype wire
